// File: source/lot_pkg.sv
/* Parking tower geometry and plate classes
   Spot encoding plus the rules that sort plates into sedan, SUV and disabled */
`default_nettype none

package lot_pkg;

	// Seven parking floors above the floor 0 bay
	localparam int num_floors = 7;
	// Indices 0 and 1 fall on the bay floor and never hold a car
	localparam int num_spots = 16;

	// Non-reserved capacity per class
	localparam int suv_spots = 7;
	localparam int sedan_spots = 5;

	localparam logic [3:0] disabled_digit = 4'd9;

	// Four BCD digits, zero marks an empty spot
	typedef logic [15:0] plate_t;
	typedef logic [2:0] floor_t;

	// Left places up to this floor are held for disabled plates
	localparam floor_t reserved_top_floor = 3'd2;

	// Flat index for storage, floor and place for the elevator
	typedef union packed {
		logic [3:0] index;
		struct packed {
			floor_t floor;
			logic   place;
		} loc;
	} spot_t;

	function automatic logic [3:0] lead_digit(plate_t plate);
		return plate[15:12];
	endfunction

	function automatic logic is_disabled(plate_t plate);
		return lead_digit(plate) == disabled_digit;
	endfunction

	// Odd last digit
	function automatic logic is_suv(plate_t plate);
		return plate[0];
	endfunction

	function automatic logic is_parking_floor(floor_t floor);
		return (floor != '0) && (int'(floor) <= num_floors);
	endfunction

	function automatic logic is_suv_floor(floor_t floor);
		return floor[0];
	endfunction

	function automatic logic is_reserved(spot_t spot);
		return (spot.loc.place == 1'b0) && (spot.loc.floor != '0) &&
			(spot.loc.floor <= reserved_top_floor);
	endfunction

endpackage

`default_nettype wire

// File: source/order_pkg.sv
/* Order kinds, queue sizing, elevator step codes and fee rates */
`default_nettype none

package order_pkg;

	typedef enum logic {
		order_park = 1'b0,
		order_retrieve = 1'b1
	} order_kind_t;

	localparam int queue_depth = 8;
	localparam int queue_ptr_bits = $clog2(queue_depth);

	// Elevator sequence for one order
	localparam logic [2:0] step_idle = 3'd0;
	localparam logic [2:0] step_load = 3'd1;
	localparam logic [2:0] step_travel_up = 3'd2;
	localparam logic [2:0] step_transfer = 3'd3;
	localparam logic [2:0] step_travel_down = 3'd4;
	localparam logic [2:0] step_done = 3'd5;

	localparam logic [3:0] hybrid_digit = 4'd8;

	typedef logic [7:0] fee_t;

	// Charge per cycle of occupancy
	localparam fee_t rate_disabled = 8'd0;
	localparam fee_t rate_hybrid = 8'd1;
	localparam fee_t rate_standard = 8'd2;
	localparam fee_t fee_max = 8'd255;

endpackage

`default_nettype wire

// File: source/order_queue.sv
/* Request FIFO between the external channel and the elevator
   Holds park and retrieve orders with back-pressure when full */
`timescale 1ns/10ps
`default_nettype none

module order_queue (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   request_valid,
	input  order_pkg::order_kind_t request_kind,
	input  lot_pkg::plate_t        request_plate,
	input  logic                   head_take,
	output logic                   request_ready,
	output logic                   head_valid,
	output order_pkg::order_kind_t head_kind,
	output lot_pkg::plate_t        head_plate
);

	order_pkg::order_kind_t kind_mem [order_pkg::queue_depth];
	lot_pkg::plate_t plate_mem [order_pkg::queue_depth];

	logic [order_pkg::queue_ptr_bits-1:0] wr_ptr;
	logic [order_pkg::queue_ptr_bits-1:0] rd_ptr;
	logic [order_pkg::queue_ptr_bits:0] count;
	logic push;
	logic pop;

	assign request_ready = count != (order_pkg::queue_ptr_bits + 1)'(order_pkg::queue_depth);
	assign head_valid = count != '0;
	assign push = request_valid && request_ready;
	assign pop = head_take && head_valid;

	assign head_kind = kind_mem[rd_ptr];
	assign head_plate = plate_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			kind_mem[wr_ptr] <= request_kind;
			plate_mem[wr_ptr] <= request_plate;
		end
	end

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/slot_allocator.sv
/* Free-spot search by car class, plate lookup and free counts
   Purely combinational over the current table contents */
`timescale 1ns/10ps
`default_nettype none

module slot_allocator (
	input  lot_pkg::plate_t [lot_pkg::num_spots-1:0] spot_plates,
	input  lot_pkg::plate_t                          order_plate,
	output logic                                     free_found,
	output lot_pkg::spot_t                           free_spot,
	output logic                                     match_found,
	output lot_pkg::spot_t                           match_spot,
	output logic [3:0]                               empty_suv,
	output logic [3:0]                               empty_sedan
);

	logic order_suv;
	logic order_disabled;
	logic own_found;
	logic alt_found;
	lot_pkg::spot_t own_spot;
	lot_pkg::spot_t alt_spot;

	assign order_suv = lot_pkg::is_suv(order_plate);
	assign order_disabled = lot_pkg::is_disabled(order_plate);

	always_comb begin
		lot_pkg::spot_t spot;
		logic parking;
		logic vacant;
		logic suv_floor;
		own_found = 1'b0;
		alt_found = 1'b0;
		own_spot = '0;
		alt_spot = '0;
		match_found = 1'b0;
		match_spot = '0;
		empty_suv = '0;
		empty_sedan = '0;
		// Walk downwards so the lowest floor and the left place win
		for (int i = lot_pkg::num_spots - 1; i >= 0; i--) begin
			spot.index = 4'(i);
			parking = lot_pkg::is_parking_floor(spot.loc.floor);
			vacant = parking && (spot_plates[i] == '0);
			suv_floor = lot_pkg::is_suv_floor(spot.loc.floor);
			if (vacant && !lot_pkg::is_reserved(spot)) begin
				if (suv_floor) begin
					empty_suv = empty_suv + 4'd1;
				end else begin
					empty_sedan = empty_sedan + 4'd1;
				end
			end
			if (vacant && (order_disabled || !lot_pkg::is_reserved(spot))) begin
				if (suv_floor == order_suv) begin
					own_found = 1'b1;
					own_spot = spot;
				end else if (suv_floor) begin
					// Sedan fallback onto an SUV floor
					alt_found = 1'b1;
					alt_spot = spot;
				end
			end
			if (parking && (order_plate != '0) && (spot_plates[i] == order_plate)) begin
				match_found = 1'b1;
				match_spot = spot;
			end
		end
		free_found = own_found || alt_found;
		free_spot = own_found ? own_spot : alt_spot;
	end

endmodule

`default_nettype wire

// File: source/occupancy_table.sv
/* Plate store for every spot of the tower
   One spot is written per store pulse, plate zero empties it */
`timescale 1ns/10ps
`default_nettype none

module occupancy_table (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic                                     store_en,
	input  lot_pkg::spot_t                           store_spot,
	input  lot_pkg::plate_t                          store_plate,
	output lot_pkg::plate_t [lot_pkg::num_spots-1:0] spot_plates
);

	// Tower starts empty
	always_ff @(posedge clock) begin
		if (reset) begin
			spot_plates <= '0;
		end else if (store_en) begin
			spot_plates[store_spot.index] <= store_plate;
		end
	end

endmodule

`default_nettype wire

// File: source/fee_meter.sv
/* Per-spot parking fee accumulators
   Rate depends on the plate class and the total saturates */
`timescale 1ns/10ps
`default_nettype none

module fee_meter (
	input  logic                                     clock,
	input  logic                                     reset,
	input  lot_pkg::plate_t [lot_pkg::num_spots-1:0] spot_plates,
	input  logic                                     store_en,
	input  lot_pkg::spot_t                           store_spot,
	input  lot_pkg::spot_t                           fee_spot,
	output order_pkg::fee_t                          spot_fee
);

	order_pkg::fee_t [lot_pkg::num_spots-1:0] fee_acc;
	order_pkg::fee_t [lot_pkg::num_spots-1:0] fee_next;

	function automatic order_pkg::fee_t rate_of(lot_pkg::plate_t plate);
		order_pkg::fee_t rate;
		if (lot_pkg::is_disabled(plate)) begin
			rate = order_pkg::rate_disabled;
		end else if (lot_pkg::lead_digit(plate) == order_pkg::hybrid_digit) begin
			rate = order_pkg::rate_hybrid;
		end else begin
			rate = order_pkg::rate_standard;
		end
		return rate;
	endfunction

	function automatic order_pkg::fee_t add_sat(order_pkg::fee_t fee, order_pkg::fee_t rate);
		logic [8:0] sum;
		sum = {1'b0, fee} + {1'b0, rate};
		if (sum > {1'b0, order_pkg::fee_max}) begin
			sum = {1'b0, order_pkg::fee_max};
		end
		return sum[7:0];
	endfunction

	always_comb begin
		for (int i = 0; i < lot_pkg::num_spots; i++) begin
			fee_next[i] = fee_acc[i];
			// A write to the spot starts a new stay
			if (store_en && (store_spot.index == 4'(i))) begin
				fee_next[i] = '0;
			end else if (spot_plates[i] != '0) begin
				fee_next[i] = add_sat(fee_acc[i], rate_of(spot_plates[i]));
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fee_acc <= '0;
		end else begin
			fee_acc <= fee_next;
		end
	end

	assign spot_fee = fee_acc[fee_spot.index];

endmodule

`default_nettype wire

// File: source/elevator_controller.sv
/* Elevator FSM serving one order at a time
   Loads or fetches a car, moves one floor per cycle and reports completion */
`timescale 1ns/10ps
`default_nettype none

module elevator_controller (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   head_valid,
	input  order_pkg::order_kind_t head_kind,
	input  lot_pkg::plate_t        head_plate,
	input  logic                   free_found,
	input  lot_pkg::spot_t         free_spot,
	input  logic                   match_found,
	input  lot_pkg::spot_t         match_spot,
	input  order_pkg::fee_t        spot_fee,
	output logic                   head_take,
	output lot_pkg::plate_t        order_plate,
	output logic                   store_en,
	output lot_pkg::spot_t         store_spot,
	output lot_pkg::plate_t        store_plate,
	output lot_pkg::spot_t         fee_spot,
	output lot_pkg::floor_t        current_floor,
	output logic                   done_valid,
	output order_pkg::order_kind_t done_kind,
	output lot_pkg::plate_t        done_plate,
	output logic                   done_found,
	output lot_pkg::spot_t         done_spot,
	output order_pkg::fee_t        done_fee
);

	logic [2:0] step;
	logic is_park;
	logic pick_found;
	lot_pkg::spot_t pick_spot;

	order_pkg::order_kind_t kind_q;
	lot_pkg::plate_t plate_q;
	logic found_q;
	lot_pkg::spot_t spot_q;
	order_pkg::fee_t fee_q;

	// Decision taken from the table as it stands in the pop cycle
	assign is_park = head_kind == order_pkg::order_park;
	assign pick_found = is_park ? free_found : match_found;
	assign pick_spot = !pick_found ? '0 : (is_park ? free_spot : match_spot);

	assign head_take = (step == order_pkg::step_idle) && head_valid;
	assign order_plate = (step == order_pkg::step_idle) ? head_plate : plate_q;

	// Transfer writes the car in for a park and clears the spot for a retrieve
	assign store_en = step == order_pkg::step_transfer;
	assign store_spot = spot_q;
	assign store_plate = (kind_q == order_pkg::order_park) ? plate_q : '0;
	assign fee_spot = spot_q;

	assign done_valid = step == order_pkg::step_done;
	assign done_kind = kind_q;
	assign done_plate = plate_q;
	assign done_found = found_q;
	assign done_spot = spot_q;
	assign done_fee = fee_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= order_pkg::step_idle;
			current_floor <= '0;
		end else begin
			case (step)
				order_pkg::step_idle: begin
					if (head_take) begin
						if (!pick_found) begin
							step <= order_pkg::step_done;
						end else if (is_park) begin
							step <= order_pkg::step_load;
						end else begin
							step <= order_pkg::step_travel_up;
						end
					end
				end
				order_pkg::step_load: step <= order_pkg::step_travel_up;
				order_pkg::step_travel_up: begin
					current_floor <= current_floor + 3'd1;
					if (current_floor + 3'd1 == spot_q.loc.floor) begin
						step <= order_pkg::step_transfer;
					end
				end
				order_pkg::step_transfer: step <= order_pkg::step_travel_down;
				order_pkg::step_travel_down: begin
					current_floor <= current_floor - 3'd1;
					if (current_floor == 3'd1) begin
						step <= order_pkg::step_done;
					end
				end
				default: step <= order_pkg::step_idle;
			endcase
		end
	end

	// Order details held until the done pulse
	always_ff @(posedge clock) begin
		if (head_take) begin
			kind_q <= head_kind;
			plate_q <= head_plate;
			found_q <= pick_found;
			spot_q <= pick_spot;
			fee_q <= '0;
		end else if (store_en && (kind_q == order_pkg::order_retrieve)) begin
			fee_q <= spot_fee;
		end
	end

endmodule

`default_nettype wire

// File: source/parking_tower_top.sv
/* Parking tower top level
   Connects the request queue, allocator, plate table, fee meter and elevator */
`timescale 1ns/10ps
`default_nettype none

module parking_tower_top (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   request_valid,
	input  order_pkg::order_kind_t request_kind,
	input  lot_pkg::plate_t        request_plate,
	output logic                   request_ready,
	output logic                   done_valid,
	output order_pkg::order_kind_t done_kind,
	output lot_pkg::plate_t        done_plate,
	output logic                   done_found,
	output lot_pkg::spot_t         done_spot,
	output order_pkg::fee_t        done_fee,
	output lot_pkg::floor_t        current_floor,
	output logic [3:0]             empty_suv,
	output logic [3:0]             empty_sedan
);

	logic head_valid;
	order_pkg::order_kind_t head_kind;
	lot_pkg::plate_t head_plate;
	logic head_take;

	lot_pkg::plate_t [lot_pkg::num_spots-1:0] spot_plates;
	lot_pkg::plate_t order_plate;
	logic free_found;
	lot_pkg::spot_t free_spot;
	logic match_found;
	lot_pkg::spot_t match_spot;

	logic store_en;
	lot_pkg::spot_t store_spot;
	lot_pkg::plate_t store_plate;
	lot_pkg::spot_t fee_spot;
	order_pkg::fee_t spot_fee;

	order_queue i_order_queue (
		.clock         (clock),
		.reset         (reset),
		.request_valid (request_valid),
		.request_kind  (request_kind),
		.request_plate (request_plate),
		.head_take     (head_take),
		.request_ready (request_ready),
		.head_valid    (head_valid),
		.head_kind     (head_kind),
		.head_plate    (head_plate)
	);

	slot_allocator i_slot_allocator (
		.spot_plates (spot_plates),
		.order_plate (order_plate),
		.free_found  (free_found),
		.free_spot   (free_spot),
		.match_found (match_found),
		.match_spot  (match_spot),
		.empty_suv   (empty_suv),
		.empty_sedan (empty_sedan)
	);

	occupancy_table i_occupancy_table (
		.clock       (clock),
		.reset       (reset),
		.store_en    (store_en),
		.store_spot  (store_spot),
		.store_plate (store_plate),
		.spot_plates (spot_plates)
	);

	// Sees the same store pulse as the table
	fee_meter i_fee_meter (
		.clock       (clock),
		.reset       (reset),
		.spot_plates (spot_plates),
		.store_en    (store_en),
		.store_spot  (store_spot),
		.fee_spot    (fee_spot),
		.spot_fee    (spot_fee)
	);

	elevator_controller i_elevator_controller (
		.clock         (clock),
		.reset         (reset),
		.head_valid    (head_valid),
		.head_kind     (head_kind),
		.head_plate    (head_plate),
		.free_found    (free_found),
		.free_spot     (free_spot),
		.match_found   (match_found),
		.match_spot    (match_spot),
		.spot_fee      (spot_fee),
		.head_take     (head_take),
		.order_plate   (order_plate),
		.store_en      (store_en),
		.store_spot    (store_spot),
		.store_plate   (store_plate),
		.fee_spot      (fee_spot),
		.current_floor (current_floor),
		.done_valid    (done_valid),
		.done_kind     (done_kind),
		.done_plate    (done_plate),
		.done_found    (done_found),
		.done_spot     (done_spot),
		.done_fee      (done_fee)
	);

endmodule

`default_nettype wire

// File: verification/parking_tower_assert.sv
/* Bound checks on the parking tower top level
   Elevator position and motion, completion pulse width and free counts */
`timescale 1ns/10ps
`default_nettype none

module parking_tower_assert (
	input logic            clock,
	input logic            reset,
	input lot_pkg::floor_t current_floor,
	input logic            done_valid,
	input logic [3:0]      empty_suv,
	input logic [3:0]      empty_sedan
);

	// Number of failed assertions
	int failure_count = 0;

	// Every order ends with the car back at the bay
	done_at_bay: assert property (@(posedge clock) disable iff (reset)
		done_valid |-> (current_floor == '0))
	else begin
		failure_count++;
		$error("completion reported while the elevator is away from the bay");
	end

	// One floor per cycle at most
	floor_step: assert property (@(posedge clock) disable iff (reset)
		(int'(current_floor) - int'($past(current_floor))) inside {-1, 0, 1})
	else begin
		failure_count++;
		$error("elevator moved more than one floor in a cycle");
	end

	done_single: assert property (@(posedge clock) disable iff (reset)
		done_valid |=> !done_valid)
	else begin
		failure_count++;
		$error("done_valid high for two cycles");
	end

	free_bounds: assert property (@(posedge clock) disable iff (reset)
		(empty_suv <= 4'(lot_pkg::suv_spots)) && (empty_sedan <= 4'(lot_pkg::sedan_spots)))
	else begin
		failure_count++;
		$error("free count above the class capacity");
	end

endmodule

bind parking_tower_top parking_tower_assert i_parking_tower_assert (
	.clock         (clock),
	.reset         (reset),
	.current_floor (current_floor),
	.done_valid    (done_valid),
	.empty_suv     (empty_suv),
	.empty_sedan   (empty_sedan)
);

`default_nettype wire

// File: verification/parking_tower_tb.sv
/* Parking tower testbench
   Parks, retrieves and bursts requests against a shadow model of the tower */
`timescale 1ns/10ps
`default_nettype none

module parking_tower_tb;

	logic clock;
	logic reset;
	logic request_valid;
	order_pkg::order_kind_t request_kind;
	lot_pkg::plate_t request_plate;
	logic request_ready;
	logic done_valid;
	order_pkg::order_kind_t done_kind;
	lot_pkg::plate_t done_plate;
	logic done_found;
	lot_pkg::spot_t done_spot;
	order_pkg::fee_t done_fee;
	lot_pkg::floor_t current_floor;
	logic [3:0] empty_suv;
	logic [3:0] empty_sedan;

	// Shadow of the tower, indexed by floor * 2 + place
	lot_pkg::plate_t shadow [16];
	lot_pkg::plate_t parked [$];
	// Kind, plate, found, spot, free SUV count, free sedan count
	logic [29:0] expected [$];
	logic [31:0] lfsr_state;
	int issued;
	int completed;
	int errors;
	int cycles;
	logic ready_dropped;

	parking_tower_top i_parking_tower_top (.*);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic random_bit();
		lfsr_state = {lfsr_state[30:0],
			lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
		return lfsr_state[0];
	endfunction

	function automatic logic [3:0] random_digit();
		logic [3:0] bits;
		bits = '0;
		for (int i = 0; i < 4; i++) begin
			bits = {bits[2:0], random_bit()};
		end
		return bits % 4'd10;
	endfunction

	// Lead digit 0 asks for a standard plate
	function automatic lot_pkg::plate_t make_plate(logic [3:0] lead, logic suv);
		lot_pkg::plate_t plate;
		plate[15:12] = (lead == 4'd0) ? 4'd1 + random_digit() % 4'd7 : lead;
		plate[11:8] = random_digit();
		plate[7:4] = random_digit();
		plate[3:0] = random_digit();
		plate[0] = suv;
		return plate;
	endfunction

	// Lowest floor first, left before right, sedans spill onto SUV floors
	function automatic logic [4:0] reference_spot(order_pkg::order_kind_t kind,
		lot_pkg::plate_t plate);
		logic want_odd;
		if (kind == order_pkg::order_retrieve) begin
			for (int s = 2; s < 16; s++) begin
				if (shadow[s] == plate) begin
					return {1'b1, 4'(s)};
				end
			end
			return '0;
		end
		for (int pass = 0; pass < 2; pass++) begin
			want_odd = (pass == 1) || plate[0];
			for (int f = 1; f <= lot_pkg::num_floors; f++) begin
				for (int p = 0; p < 2; p++) begin
					if (((f % 2 == 1) == want_odd) && (shadow[f * 2 + p] == '0) &&
						!(p == 0 && f <= 2 && plate[15:12] != lot_pkg::disabled_digit)) begin
						return {1'b1, 4'(f * 2 + p)};
					end
				end
			end
		end
		return '0;
	endfunction

	// Free places of one class, reserved places left out
	function automatic logic [3:0] free_count(logic suv);
		logic [3:0] total;
		total = '0;
		for (int f = 1; f <= lot_pkg::num_floors; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (((f % 2 == 1) == suv) && !(p == 0 && f <= 2) && (shadow[f * 2 + p] == '0)) begin
					total++;
				end
			end
		end
		return total;
	endfunction

	function automatic logic fee_ok(logic [29:0] entry, order_pkg::fee_t fee);
		if ((entry[29] != order_pkg::order_retrieve) || !entry[12]) begin
			return fee == 8'd0;
		end else if (entry[28:25] == lot_pkg::disabled_digit) begin
			return fee == 8'd0;
		end else if (entry[28:25] == order_pkg::hybrid_digit) begin
			return fee != 8'd0;
		end
		return (fee != 8'd0) && ((fee[0] == 1'b0) || (fee == 8'd255));
	endfunction

	task automatic report_mismatch(string what);
		errors++;
		$display("Mismatch at %0t: %s", $time, what);
	endtask

	task automatic send_request(order_pkg::order_kind_t kind, lot_pkg::plate_t plate);
		logic [4:0] result;
		logic taken;
		result = reference_spot(kind, plate);
		request_valid = 1'b1;
		request_kind = kind;
		request_plate = plate;
		taken = 1'b0;
		// Ready only moves on an edge, so this value holds for the coming edge
		while (!taken) begin
			taken = request_ready;
			if (!taken) begin
				ready_dropped = 1'b1;
			end
			@(posedge clock);
			#1;
		end
		request_valid = 1'b0;
		if (result[4]) begin
			shadow[result[3:0]] = (kind == order_pkg::order_park) ? plate : '0;
		end
		if (result[4] && (kind == order_pkg::order_park)) begin
			parked.push_back(plate);
		end
		expected.push_back({kind, plate, result, free_count(1'b1), free_count(1'b0)});
		issued++;
	endtask

	task automatic park_cars(int count, logic [3:0] lead, logic suv);
		for (int i = 0; i < count; i++) begin
			send_request(order_pkg::order_park, make_plate(lead, suv));
		end
	endtask

	task automatic wait_for_drain();
		while (completed != issued) begin
			@(posedge clock);
			#1;
		end
	endtask

	always @(negedge clock) begin
		logic [29:0] entry;
		if (!reset && done_valid) begin
			completed++;
			if (expected.size() == 0) begin
				errors++;
				$display("Error at %0t: a completion arrived with no request pending", $time);
			end else begin
				entry = expected.pop_front();
				if ((done_kind != entry[29]) || (done_plate != entry[28:13])) begin
					report_mismatch($sformatf("order %h, expected %h", done_plate, entry[28:13]));
				end
				if (done_found != entry[12]) begin
					report_mismatch($sformatf("plate %h found %b", done_plate, done_found));
				end else if (entry[12] && (done_spot.index != entry[11:8])) begin
					report_mismatch($sformatf("plate %h spot %0d, expected %0d",
						done_plate, done_spot.index, entry[11:8]));
				end
				if ((empty_suv != entry[7:4]) || (empty_sedan != entry[3:0])) begin
					report_mismatch($sformatf("free counts %0d/%0d, expected %0d/%0d",
						empty_suv, empty_sedan, entry[7:4], entry[3:0]));
				end
				if (!fee_ok(entry, done_fee)) begin
					report_mismatch($sformatf("plate %h fee %0d", done_plate, done_fee));
				end
			end
		end
	end

	// 64 cycles for each request issued so far
	initial begin
		cycles = 0;
		while (cycles <= 64 * (issued + 1)) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout after %0d cycles: the elevator stopped completing requests", cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		lot_pkg::plate_t again;
		reset = 1'b1;
		request_valid = 1'b0;
		request_kind = order_pkg::order_park;
		request_plate = '0;
		lfsr_state = 32'hd29d_6982;
		issued = 0;
		completed = 0;
		errors = 0;
		ready_dropped = 1'b0;
		foreach (shadow[i]) begin
			shadow[i] = '0;
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		// Disabled, hybrid and standard cars of both classes
		park_cars(1, lot_pkg::disabled_digit, 1'b1);
		park_cars(1, lot_pkg::disabled_digit, 1'b0);
		park_cars(2, order_pkg::hybrid_digit, 1'b0);
		park_cars(1, order_pkg::hybrid_digit, 1'b1);
		park_cars(2, 4'd0, 1'b0);
		park_cars(3, 4'd0, 1'b1);
		// Last sedan spot, one overflow, SUV floors filled, then rejections
		park_cars(2, 4'd0, 1'b0);
		park_cars(3, 4'd0, 1'b1);
		park_cars(1, 4'd0, 1'b0);
		park_cars(1, lot_pkg::disabled_digit, 1'b0);

		again = parked[0];
		while (parked.size() != 0) begin
			send_request(order_pkg::order_retrieve, parked.pop_front());
		end
		// Lead digit 0 is never generated, so this plate is unknown
		send_request(order_pkg::order_retrieve, 16'h0001);
		send_request(order_pkg::order_retrieve, again);
		wait_for_drain();

		// Burst deeper than the queue
		ready_dropped = 1'b0;
		for (int i = 0; i < 12; i++) begin
			park_cars(1, 4'd0, random_bit());
		end
		wait_for_drain();
		if (!ready_dropped) begin
			errors++;
			$display("Error: request_ready never went low during the burst");
		end

		errors += i_parking_tower_top.i_parking_tower_assert.failure_count;
		$display("Summary: %0d requests, %0d completions, %0d errors", issued, completed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
source/lot_pkg.sv
source/order_pkg.sv
source/order_queue.sv
source/slot_allocator.sv
source/occupancy_table.sv
source/fee_meter.sv
source/elevator_controller.sv
source/parking_tower_top.sv
verification/parking_tower_assert.sv
verification/parking_tower_tb.sv
